// ==== common/iob_if.sv ====
`timescale 1ns/1ps

interface iob_if
  import soc_bus_pkg::*;
();

  logic              avalid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              ready;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;

  modport mgr (
    output avalid,
    output addr,
    output wdata,
    output wstrb,
    input  ready,
    input  rvalid,
    input  rdata
  );

  modport sub (
    input  avalid,
    input  addr,
    input  wdata,
    input  wstrb,
    output ready,
    output rvalid,
    output rdata
  );

endinterface

// ==== common/soc_bus_pkg.sv ====
package soc_bus_pkg;
  import soc_map_pkg::*;

  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int STRB_W = DATA_W / 8;
  localparam int BYTE_OFF_W = $clog2(STRB_W);

  // Address bits between the slot index and the default word index
  localparam int INT_HI_W = SLOT_LSB - BANK_ADDR_W_DEF - BYTE_OFF_W;

  // External memory view, B bit set
  typedef struct packed {
    logic                sel;
    logic [ADDR_W-2:0]   addr;
  } ext_addr_t;

  // Internal slot view, B bit clear
  typedef struct packed {
    logic                       sel;
    logic                       spare;
    logic [SLOT_IDX_W-1:0]      slot;
    logic [INT_HI_W-1:0]        hi;
    logic [BANK_ADDR_W_DEF-1:0] word;
    logic [BYTE_OFF_W-1:0]      byte_off;
  } int_addr_t;

  // One request address, decoded either way
  typedef union packed {
    ext_addr_t ext_view;
    int_addr_t int_view;
  } bus_addr_u;

endpackage

// ==== common/soc_map_pkg.sv ====
package soc_map_pkg;

  // Slot index sits in address bits 29:28, just below the spare bit
  localparam int SLOT_IDX_W = 2;
  localparam int SLOT_LSB = 28;

  // Every slot index decodes to a bank
  localparam int N_SLOTS = 1 << SLOT_IDX_W;

  // Response target numbers run 0..N_SLOTS, N_SLOTS is external memory
  localparam int TGT_W = $clog2(N_SLOTS + 1);

  // 64 words per bank
  localparam int BANK_ADDR_W_DEF = 6;

  // Added to every external byte address
  localparam logic [31:0] EXT_OFFSET_DEF = 32'h0000_1000;

  // Outstanding reads tracked for in-order return
  localparam int RESP_DEPTH_DEF = 4;

endpackage

// ==== fabric/bus_split.sv ====
`timescale 1ns/1ps

module bus_split
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int                BANK_ADDR_W = BANK_ADDR_W_DEF,
  parameter logic [ADDR_W-1:0] EXT_OFFSET  = EXT_OFFSET_DEF
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              avalid_i,
  input  bus_addr_u         addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic              ready_o,
  iob_if.mgr                slot_bus [N_SLOTS],
  output logic              ext_avalid_o,
  output logic [ADDR_W-1:0] ext_addr_o,
  output logic [DATA_W-1:0] ext_wdata_o,
  output logic [STRB_W-1:0] ext_wstrb_o,
  input  logic              ext_ready_i,
  output logic              tag_push_o,
  output logic [TGT_W-1:0]  tag_target_o,
  input  logic              tags_full_i,
  input  logic [TGT_W-1:0]  last_target_i,
  input  logic              pending_i
);

  logic                             bus_en;
  logic                             is_ext;
  logic                             is_read;
  logic [SLOT_IDX_W-1:0]            slot_sel;
  logic [INT_HI_W+BANK_ADDR_W_DEF-1:0] word_idx;
  logic [ADDR_W-1:0]                bank_addr;
  logic [TGT_W-1:0]                 target;
  logic [N_SLOTS-1:0]               slot_ready;
  logic                             tgt_ready;
  logic                             stall;
  logic                             req_go;

  // No request leaves in the cycle reset releases
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_en <= 1'b0;
    end else begin
      bus_en <= 1'b1;
    end
  end

  assign is_ext   = addr_i.ext_view.sel;
  assign is_read  = (wstrb_i == '0);
  assign slot_sel = addr_i.int_view.slot;
  assign word_idx = {addr_i.int_view.hi, addr_i.int_view.word};

  // Bank-local byte address, word aligned
  assign bank_addr = ADDR_W'({word_idx[BANK_ADDR_W-1:0], {BYTE_OFF_W{1'b0}}});

  assign target = is_ext ? TGT_W'(N_SLOTS) : TGT_W'(slot_sel);

  // Reads wait while another target still owes responses
  assign stall = !bus_en ||
                 (is_read && (tags_full_i || (pending_i && (last_target_i != target))));

  assign req_go = avalid_i && !stall;

  for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
    assign slot_bus[g].avalid = req_go && !is_ext && (slot_sel == SLOT_IDX_W'(g));
    assign slot_bus[g].addr   = bank_addr;
    assign slot_bus[g].wdata  = wdata_i;
    assign slot_bus[g].wstrb  = wstrb_i;
    assign slot_ready[g]      = slot_bus[g].ready;
  end

  assign ext_avalid_o = req_go && is_ext;
  assign ext_addr_o   = {1'b0, addr_i.ext_view.addr} + EXT_OFFSET;
  assign ext_wdata_o  = wdata_i;
  assign ext_wstrb_o  = wstrb_i;

  assign tgt_ready = is_ext ? ext_ready_i : slot_ready[slot_sel];
  assign ready_o   = !stall && tgt_ready;

  // One tag per accepted read
  assign tag_push_o   = avalid_i && ready_o && is_read;
  assign tag_target_o = target;

endmodule

// ==== fabric/resp_merge.sv ====
`timescale 1ns/1ps

module resp_merge
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int RESP_DEPTH = RESP_DEPTH_DEF
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic [N_SLOTS-1:0] slot_rvalid_i,
  input  logic [DATA_W-1:0] slot_rdata_i [N_SLOTS],
  input  logic              ext_rvalid_i,
  input  logic [DATA_W-1:0] ext_rdata_i,
  input  logic              tag_push_i,
  input  logic [TGT_W-1:0]  tag_target_i,
  output logic              tags_full_o,
  output logic [TGT_W-1:0]  last_target_o,
  output logic              pending_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o
);

  localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
  localparam int CNT_W = $clog2(RESP_DEPTH + 1);

  logic [TGT_W-1:0] tag_mem [RESP_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [TGT_W-1:0] head_tgt;
  logic             head_ext;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(RESP_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_tgt    = tag_mem[rd_ptr];
  assign head_ext    = (head_tgt == TGT_W'(N_SLOTS));
  assign pending_o   = (count != '0);
  assign tags_full_o = (count == CNT_W'(RESP_DEPTH));

  // Only the oldest outstanding target may answer
  always_comb begin
    if (head_ext) begin
      rvalid_o = pending_o && ext_rvalid_i;
      rdata_o  = ext_rdata_i;
    end else begin
      rvalid_o = pending_o && slot_rvalid_i[head_tgt[SLOT_IDX_W-1:0]];
      rdata_o  = slot_rdata_i[head_tgt[SLOT_IDX_W-1:0]];
    end
  end

  assign pop = rvalid_o;

  always_ff @(posedge clk_i) begin
    if (tag_push_i) begin
      tag_mem[wr_ptr] <= tag_target_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      last_target_o <= '0;
    end else begin
      if (tag_push_i) begin
        wr_ptr        <= ptr_next(wr_ptr);
        last_target_o <= tag_target_i;
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({tag_push_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== files.f ====
common/soc_map_pkg.sv
common/soc_bus_pkg.sv
common/iob_if.sv
fabric/bus_split.sv
fabric/resp_merge.sv
hdl/sram_bank.sv
hdl/soc_bus_fabric.sv
sim/tb_clk_gen.sv
sim/ext_mem_model.sv
sim/tb_soc_bus_fabric.sv

// ==== hdl/soc_bus_fabric.sv ====
`timescale 1ns/1ps

module soc_bus_fabric
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
#(
  parameter int                BANK_ADDR_W = BANK_ADDR_W_DEF,
  parameter logic [ADDR_W-1:0] EXT_OFFSET  = EXT_OFFSET_DEF,
  parameter int                RESP_DEPTH  = RESP_DEPTH_DEF
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Requester side
  input  logic              avalid_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic              ready_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  // External memory
  output logic              ext_avalid_o,
  output logic [ADDR_W-1:0] ext_addr_o,
  output logic [DATA_W-1:0] ext_wdata_o,
  output logic [STRB_W-1:0] ext_wstrb_o,
  input  logic              ext_ready_i,
  input  logic              ext_rvalid_i,
  input  logic [DATA_W-1:0] ext_rdata_i
);

  iob_if slot_bus [N_SLOTS] ();

  logic [N_SLOTS-1:0] slot_rvalid;
  logic [DATA_W-1:0]  slot_rdata [N_SLOTS];
  logic               tag_push;
  logic [TGT_W-1:0]   tag_target;
  logic               tags_full;
  logic [TGT_W-1:0]   last_target;
  logic               pending;

  bus_split #(
    .BANK_ADDR_W(BANK_ADDR_W),
    .EXT_OFFSET (EXT_OFFSET)
  ) split0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .avalid_i     (avalid_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .ready_o      (ready_o),
    .slot_bus     (slot_bus),
    .ext_avalid_o (ext_avalid_o),
    .ext_addr_o   (ext_addr_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_wstrb_o  (ext_wstrb_o),
    .ext_ready_i  (ext_ready_i),
    .tag_push_o   (tag_push),
    .tag_target_o (tag_target),
    .tags_full_i  (tags_full),
    .last_target_i(last_target),
    .pending_i    (pending)
  );

  // Every internal slot is an SRAM bank
  for (genvar g = 0; g < N_SLOTS; g++) begin : g_bank
    sram_bank #(
      .BANK_ADDR_W(BANK_ADDR_W)
    ) bank0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .bus    (slot_bus[g])
    );

    assign slot_rvalid[g] = slot_bus[g].rvalid;
    assign slot_rdata[g]  = slot_bus[g].rdata;
  end

  resp_merge #(
    .RESP_DEPTH(RESP_DEPTH)
  ) merge0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .slot_rvalid_i(slot_rvalid),
    .slot_rdata_i (slot_rdata),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .tag_push_i   (tag_push),
    .tag_target_i (tag_target),
    .tags_full_o  (tags_full),
    .last_target_o(last_target),
    .pending_o    (pending),
    .rvalid_o     (rvalid_o),
    .rdata_o      (rdata_o)
  );

endmodule

// ==== hdl/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank
  import soc_bus_pkg::*;
#(
  parameter int BANK_ADDR_W = 6
) (
  input logic clk_i,
  input logic rst_n_i,
  iob_if.sub  bus
);

  logic [DATA_W-1:0]      mem [2**BANK_ADDR_W];
  logic [BANK_ADDR_W-1:0] word_idx;
  logic                   rd_req;

  assign word_idx = bus.addr[BANK_ADDR_W+BYTE_OFF_W-1:BYTE_OFF_W];
  assign rd_req   = bus.avalid && (bus.wstrb == '0);

  // Single-cycle SRAM never back-pressures
  assign bus.ready = 1'b1;

  always_ff @(posedge clk_i) begin
    if (bus.avalid) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (bus.wstrb[b]) begin
          mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (rd_req) begin
      bus.rdata <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= rd_req;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide by the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_soc_bus_fabric -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  && grep -q "^Everything OK$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== sim/ext_mem_model.sv ====
`timescale 1ns/1ps

module ext_mem_model
  import soc_bus_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              avalid_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic [STRB_W-1:0] wstrb_i,
  output logic              ready_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic [ADDR_W-1:0] last_wr_addr_o,
  output int                wr_count_o
);

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] word_addr;
  logic              rdy_q = 1'b0;
  logic              rv_q = 1'b0;
  logic [DATA_W-1:0] rd_q = '0;
  logic              pipe_v;
  logic [DATA_W-1:0] pipe_d;
  logic [DATA_W-1:0] cur;
  integer            seed = 56338;
  integer            rnd;

  assign word_addr = {addr_i[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
  assign ready_o   = rdy_q;
  assign rvalid_o  = rv_q;
  assign rdata_o   = rd_q;

  // Read data leaves two cycles after acceptance
  always @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdy_q          <= 1'b0;
      rv_q           <= 1'b0;
      pipe_v         <= 1'b0;
      last_wr_addr_o <= '0;
      wr_count_o     <= 0;
    end else begin
      rnd = $random(seed);
      rdy_q  <= (rnd[1:0] != 2'b00);
      rv_q   <= pipe_v;
      rd_q   <= pipe_d;
      pipe_v <= 1'b0;
      if (avalid_i && rdy_q) begin
        // Unwritten words read back a pattern of their full address
        cur = mem.exists(word_addr) ? mem[word_addr] : {word_addr[15:0], word_addr[31:16]};
        if (wstrb_i == '0) begin
          pipe_v <= 1'b1;
          pipe_d <= cur;
        end else begin
          for (int b = 0; b < STRB_W; b++) begin
            if (wstrb_i[b]) begin
              cur[8*b +: 8] = wdata_i[8*b +: 8];
            end
          end
          mem[word_addr] = cur;
          last_wr_addr_o <= addr_i;
          wr_count_o     <= wr_count_o + 1;
        end
      end
    end
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  // Free-running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

endmodule

// ==== sim/tb_soc_bus_fabric.sv ====
`timescale 1ns/1ps

module tb_soc_bus_fabric
  import soc_bus_pkg::*;
  import soc_map_pkg::*;
();

  localparam logic [ADDR_W-1:0] EXT_BIT = 32'h8000_0000;

  typedef struct packed {
    logic [3:0]        test;
    logic              is_wr;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] exp;
  } row_t;

  logic              clk;
  logic              rst_n;
  logic              avalid_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              ready_o;
  logic              rvalid_o;
  logic [DATA_W-1:0] rdata_o;
  logic              ext_avalid_o;
  logic [ADDR_W-1:0] ext_addr_o;
  logic [DATA_W-1:0] ext_wdata_o;
  logic [STRB_W-1:0] ext_wstrb_o;
  logic              ext_ready_i;
  logic              ext_rvalid_i;
  logic [DATA_W-1:0] ext_rdata_i;
  logic [ADDR_W-1:0] last_wr_addr;
  int                wr_count;

  row_t              rows[$];
  logic [DATA_W-1:0] read_q[$];
  logic [ADDR_W-1:0] wr_addr_q[$];
  logic [DATA_W-1:0] int_ref [N_SLOTS][2**BANK_ADDR_W_DEF];
  logic [DATA_W-1:0] ext_ref [logic [ADDR_W-1:0]];
  int                errors = 0;
  int                checks = 0;
  int                cycles = 0;
  int                seen_writes = 0;
  int                limit = 1000;

  tb_clk_gen #(.PERIOD_NS(20)) clk0 (.clk_o(clk));

  ext_mem_model ext0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .avalid_i      (ext_avalid_o),
    .addr_i        (ext_addr_o),
    .wdata_i       (ext_wdata_o),
    .wstrb_i       (ext_wstrb_o),
    .ready_o       (ext_ready_i),
    .rvalid_o      (ext_rvalid_i),
    .rdata_o       (ext_rdata_i),
    .last_wr_addr_o(last_wr_addr),
    .wr_count_o    (wr_count)
  );

  soc_bus_fabric #(
    .BANK_ADDR_W(BANK_ADDR_W_DEF),
    .EXT_OFFSET (EXT_OFFSET_DEF),
    .RESP_DEPTH (RESP_DEPTH_DEF)
  ) dut0 (
    .clk_i  (clk),
    .rst_n_i(rst_n),
    .*
  );

  function automatic logic [ADDR_W-1:0] slot_addr(input int slot, input int word);
    return (ADDR_W'(slot) << SLOT_LSB) | (ADDR_W'(word) << BYTE_OFF_W);
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
      input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Reference memories follow the write rows in table order
  task automatic add_row(input int test, input logic [ADDR_W-1:0] a,
      input logic [DATA_W-1:0] d, input logic [STRB_W-1:0] s);
    row_t              r;
    logic [ADDR_W-1:0] key;
    int                slot;
    int                word;
    r = '{test: 4'(test), is_wr: (s != '0), addr: a, wdata: d, wstrb: s, exp: '0};
    key  = {1'b0, a[ADDR_W-2:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}};
    slot = int'(a[SLOT_LSB +: SLOT_IDX_W]);
    word = int'(a[BYTE_OFF_W +: BANK_ADDR_W_DEF]);
    if (a[ADDR_W-1] && r.is_wr) begin
      ext_ref[key] = merge_bytes(ext_ref.exists(key) ? ext_ref[key] : '0, d, s);
    end else if (a[ADDR_W-1]) begin
      r.exp = ext_ref[key];
    end else if (r.is_wr) begin
      int_ref[slot][word] = merge_bytes(int_ref[slot][word], d, s);
    end else begin
      r.exp = int_ref[slot][word];
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Same word index in every slot with distinct data
    for (int s = 0; s < N_SLOTS; s++) begin
      add_row(1, slot_addr(s, 5), 32'h1111_1111 * 32'(s + 1), 4'hF);
    end
    for (int s = 0; s < N_SLOTS; s++) begin
      add_row(1, slot_addr(s, 5), '0, '0);
    end
    add_row(2, slot_addr(1, 9), 32'h1122_3344, 4'hF);
    add_row(2, slot_addr(1, 9), 32'hAABB_CCDD, 4'b0101);
    add_row(2, slot_addr(1, 9), 32'hEE00_0000, 4'b1000);
    add_row(2, slot_addr(1, 9), '0, '0);
    add_row(3, EXT_BIT | 32'h40, 32'hCAFE_F00D, 4'hF);
    add_row(3, EXT_BIT | 32'h44, 32'h0BAD_BEEF, 4'hF);
    add_row(3, EXT_BIT | 32'h40, 32'h1234_5678, 4'b0011);
    add_row(3, EXT_BIT | 32'h40, '0, '0);
    add_row(3, EXT_BIT | 32'h44, '0, '0);
    // Reads alternate between a slot and external memory
    add_row(4, slot_addr(2, 5), '0, '0);
    add_row(4, EXT_BIT | 32'h40, '0, '0);
    add_row(4, slot_addr(0, 5), '0, '0);
    add_row(4, EXT_BIT | 32'h44, '0, '0);
    add_row(4, slot_addr(3, 5), '0, '0);
    for (int w = 0; w < 4; w++) begin
      add_row(5, slot_addr(2, w), 32'hD00D_0000 + 32'(w), 4'hF);
    end
    for (int w = 0; w < 5; w++) begin
      add_row(5, slot_addr(2, (w == 4) ? 5 : w), '0, '0);
    end
  endtask

  task automatic run_test(input int test, input string name, input bit no_wait);
    int err_start;
    int waits;
    err_start = errors;
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].test == 4'(test)) begin
        avalid_i <= 1'b1;
        addr_i   <= rows[i].addr;
        wdata_i  <= rows[i].wdata;
        wstrb_i  <= rows[i].wstrb;
        @(posedge clk);
        waits = 0;
        while (!ready_o) begin
          waits++;
          @(posedge clk);
        end
        // Same-target requests must be taken every cycle
        if (no_wait) begin
          checks++;
          assert (waits == 0) else begin
            $display("request %0d of test %0d waited %0d cycles for ready_o at %0t",
                     i, test, waits, $time);
            errors++;
          end
        end
        if (!rows[i].is_wr) begin
          read_q.push_back(rows[i].exp);
        end else if (rows[i].addr[ADDR_W-1]) begin
          wr_addr_q.push_back((rows[i].addr & ~EXT_BIT) + EXT_OFFSET_DEF);
        end
      end
    end
    avalid_i <= 1'b0;
    wstrb_i  <= '0;
    while (read_q.size() != 0 || wr_addr_q.size() != 0) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("test %0d %s: %s, %0d errors", test, name,
             (errors == err_start) ? "pass" : "FAIL", errors - err_start);
  endtask

  always @(posedge clk) begin : check_responses
    logic [DATA_W-1:0] exp_word;
    logic [ADDR_W-1:0] exp_addr;
    cycles++;
    if (rvalid_o) begin
      checks++;
      assert (read_q.size() != 0) else begin
        $display("rvalid_o pulsed at %0t with no read outstanding", $time);
        errors++;
      end
      if (read_q.size() != 0) begin
        exp_word = read_q.pop_front();
        assert (rdata_o == exp_word) else begin
          $display("ERROR %0t rdata_o expected %h got %h", $time, exp_word, rdata_o);
          errors++;
        end
      end
    end
    // The model counts every write it takes
    if (wr_count != seen_writes) begin
      seen_writes = wr_count;
      checks++;
      assert (wr_addr_q.size() != 0) else begin
        $display("external memory took a write at %0t that was never issued", $time);
        errors++;
      end
      if (wr_addr_q.size() != 0) begin
        exp_addr = wr_addr_q.pop_front();
        assert (last_wr_addr == exp_addr) else begin
          $display("ERROR %0t ext_addr_o expected %h got %h", $time, exp_addr, last_wr_addr);
          errors++;
        end
      end
    end
    if (cycles > limit) begin
      $display("Timeout after %0d cycles, a handshake or response never came", cycles);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    rst_n    = 1'b0;
    avalid_i = 1'b0;
    addr_i   = '0;
    wdata_i  = '0;
    wstrb_i  = '0;
    build_table();
    limit = 20 * rows.size() + 100;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    checks++;
    assert (!rvalid_o && !ext_avalid_o) else begin
      $display("rvalid_o or ext_avalid_o high after reset");
      errors++;
    end
    run_test(1, "one word per slot", 1'b0);
    run_test(2, "partial strobes", 1'b0);
    run_test(3, "external writes and reads", 1'b0);
    run_test(4, "alternating slot and external reads", 1'b0);
    run_test(5, "back-to-back slot reads", 1'b1);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
